//--- hw/disto_pkg.sv
/*
 * Shared definitions for the 4x4 weighted distortion datapath
 *   block geometry and weight width
 *   controller phase encoding
 *   coefficient buffer with a row view and a flat view
 */

`default_nettype none

package disto_pkg;

    // --------------------
    // Block geometry
    // --------------------

    // Block edge, fixed by the 4-point butterfly
    localparam int blk_n = 4;
    // Pixels per block, raster order
    localparam int blk_area = blk_n * blk_n;
    // One unsigned weight per coefficient position
    localparam int weight_w = 16;
    // Coefficient storage, PIX_W + 5 for pixels up to 8 bits
    localparam int coef_w = 13;

    // --------------------
    // Controller phases
    // --------------------

    // Phase applied by the datapath at the coming clock edge
    typedef enum logic [2:0] {
        ph_idle = 3'd0,
        ph_load = 3'd1,
        ph_row  = 3'd2,
        ph_col  = 3'd3,
        ph_wgt  = 3'd4,
        ph_fin  = 3'd5
    } phase_e;

    // Transform buffer
    // rows[r][c] and flat[r*blk_n+c] name the same entry
    typedef union packed {
        logic [blk_n-1:0][blk_n-1:0][coef_w-1:0] rows;
        logic [blk_area-1:0][coef_w-1:0]         flat;
    } coef_buf_u;

endpackage

`default_nettype wire

//--- hw/disto_ctrl.sv
/*
 * Sequencer for one block-pair distortion operation
 *   phase FSM over load, row, col, wgt and fin
 *   2-bit index walking each pass in four cycles
 *   accumulator clear and done pulse
 */

`timescale 1ns/1ps
`default_nettype none

module disto_ctrl import disto_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       start,
    output phase_e     phase,
    output logic [1:0] idx,
    output logic       acc_clr,
    output logic       done
);

    // Current phase and index, as applied at the last edge
    phase_e     state_q;
    logic [1:0] idx_q;

    // --------------------
    // Next phase
    // --------------------

    // Outputs carry the next state, so the datapath
    // acts on the same edge the FSM moves to it
    always_comb begin
        phase = state_q;
        case (state_q)
            ph_idle: begin
                // Only place where start is accepted
                if (start) begin
                    phase = ph_load;
                end
            end
            ph_load: begin
                phase = ph_row;
            end
            ph_row: begin
                // Row 3 done, go on to columns
                if (idx_q == 2'd3) begin
                    phase = ph_col;
                end
            end
            ph_col: begin
                if (idx_q == 2'd3) begin
                    phase = ph_wgt;
                end
            end
            ph_wgt: begin
                // Last column weighted
                if (idx_q == 2'd3) begin
                    phase = ph_fin;
                end
            end
            ph_fin: begin
                phase = ph_idle;
            end
            default: begin
                phase = ph_idle;
            end
        endcase
    end

    // Index steps inside the three passes and wraps to 0
    // at each pass boundary, held at 0 elsewhere
    always_comb begin
        if (state_q == ph_row || state_q == ph_col || state_q == ph_wgt) begin
            idx = idx_q + 2'd1;
        end else begin
            idx = 2'd0;
        end
    end

    // Accumulators cleared on the load edge
    assign acc_clr = (phase == ph_load);

    // --------------------
    // State registers
    // --------------------

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= ph_idle;
            idx_q   <= 2'd0;
            done    <= 1'b0;
        end else begin
            state_q <= phase;
            idx_q   <= idx;
            // High for the single fin cycle
            done    <= (phase == ph_fin);
        end
    end

endmodule

`default_nettype wire

//--- hw/hadamard_4x4.sv
/*
 * Two-pass 4x4 Hadamard transform engine
 *   coefficient buffer loaded from one pixel block
 *   one 4-point butterfly per cycle, rows then columns
 *   combinational read of column idx
 */

`timescale 1ns/1ps
`default_nettype none

module hadamard_4x4 import disto_pkg::*; #(
    parameter int PIX_W = 8
) (
    input  logic                        clk,
    input  logic                        arst_n,
    input  phase_e                      phase,
    input  logic [1:0]                  idx,
    input  logic [blk_area*PIX_W-1:0]   pix,
    output logic [blk_n-1:0][PIX_W+4:0] coef_col
);

    // Transform buffer, rows view for pass 1, flat view for pass 2
    coef_buf_u coef_q;

    // Column idx gathered from the flat view
    logic [blk_n-1:0][coef_w-1:0] col_sel;
    // Butterfly results for the selected row and column
    logic [blk_n-1:0][coef_w-1:0] row_bf;
    logic [blk_n-1:0][coef_w-1:0] col_bf;

    // --------------------
    // 4-point butterfly
    // --------------------

    function automatic logic [blk_n-1:0][coef_w-1:0] butterfly(
        input logic [blk_n-1:0][coef_w-1:0] x
    );
        logic signed [coef_w-1:0]     s0;
        logic signed [coef_w-1:0]     s1;
        logic signed [coef_w-1:0]     s2;
        logic signed [coef_w-1:0]     s3;
        logic [blk_n-1:0][coef_w-1:0] y;
        // First stage, even and odd pairs
        s0 = $signed(x[0]) + $signed(x[2]);
        s1 = $signed(x[1]) + $signed(x[3]);
        s2 = $signed(x[1]) - $signed(x[3]);
        s3 = $signed(x[0]) - $signed(x[2]);
        // Second stage in standard output order
        y[0] = s0 + s1;
        y[1] = s3 + s2;
        y[2] = s3 - s2;
        y[3] = s0 - s1;
        return y;
    endfunction

    // --------------------
    // Column select
    // --------------------

    always_comb begin
        for (int k = 0; k < blk_n; k++) begin
            col_sel[k]  = coef_q.flat[k*blk_n + int'(idx)];
            // Final values fit PIX_W + 5 bits
            coef_col[k] = col_sel[k][PIX_W+4:0];
        end
    end

    assign row_bf = butterfly(coef_q.rows[idx]);
    assign col_bf = butterfly(col_sel);

    // --------------------
    // Buffer update
    // --------------------

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            coef_q <= '0;
        end else begin
            case (phase)
                ph_load: begin
                    // Pixels zero-extended, raster order
                    for (int i = 0; i < blk_area; i++) begin
                        coef_q.flat[i] <= {{(coef_w-PIX_W){1'b0}}, pix[i*PIX_W +: PIX_W]};
                    end
                end
                ph_row: begin
                    coef_q.rows[idx] <= row_bf;
                end
                ph_col: begin
                    // Column written back in place, stride blk_n
                    for (int k = 0; k < blk_n; k++) begin
                        coef_q.flat[k*blk_n + int'(idx)] <= col_bf[k];
                    end
                end
                default: begin
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hw/weighted_sum_diff.sv
/*
 * Shared weighting and difference unit
 *   weight capture at load
 *   per-block sums of weight times |coefficient|
 *   registered |sum b - sum a| >> 5
 */

`timescale 1ns/1ps
`default_nettype none

module weighted_sum_diff import disto_pkg::*; #(
    parameter int PIX_W = 8
) (
    input  logic                        clk,
    input  logic                        arst_n,
    input  phase_e                      phase,
    input  logic [1:0]                  idx,
    input  logic                        acc_clr,
    input  logic [blk_area*weight_w-1:0] w,
    input  logic [blk_n-1:0][PIX_W+4:0] coef_col_a,
    input  logic [blk_n-1:0][PIX_W+4:0] coef_col_b,
    output logic [PIX_W+23:0]           sum
);

    // Accumulator width, 16 products of PIX_W+20 bits
    localparam int acc_w = PIX_W + 24;

    // Captured weights, raster order
    logic [blk_area-1:0][weight_w-1:0] w_q;
    // Weights of column idx
    logic [blk_n-1:0][weight_w-1:0]    w_col;

    logic [acc_w-1:0]        acc_a_q;
    logic [acc_w-1:0]        acc_b_q;
    logic [acc_w-1:0]        col_sum_a;
    logic [acc_w-1:0]        col_sum_b;
    logic signed [acc_w:0]   diff;
    logic [acc_w:0]          diff_abs;

    // Weighted magnitude sum of one column
    function automatic logic [acc_w-1:0] col_wsum(
        input logic [blk_n-1:0][PIX_W+4:0]    coef,
        input logic [blk_n-1:0][weight_w-1:0] wcol
    );
        logic signed [PIX_W+4:0] c;
        logic signed [PIX_W+4:0] c_neg;
        logic [PIX_W+3:0]        mag;
        logic [acc_w-1:0]        s;
        s = '0;
        for (int k = 0; k < blk_n; k++) begin
            c     = $signed(coef[k]);
            c_neg = -c;
            // Magnitude never reaches 2**(PIX_W+4)
            mag   = c[PIX_W+4] ? c_neg[PIX_W+3:0] : c[PIX_W+3:0];
            s     = s + mag * wcol[k];
        end
        return s;
    endfunction

    // --------------------
    // Column weighting
    // --------------------

    always_comb begin
        for (int k = 0; k < blk_n; k++) begin
            w_col[k] = w_q[k*blk_n + int'(idx)];
        end
    end

    assign col_sum_a = col_wsum(coef_col_a, w_col);
    assign col_sum_b = col_wsum(coef_col_b, w_col);

    // Signed difference, block b minus block a
    assign diff     = $signed({1'b0, acc_b_q}) - $signed({1'b0, acc_a_q});
    assign diff_abs = diff[acc_w] ? $unsigned(-diff) : $unsigned(diff);

    // --------------------
    // Registers
    // --------------------

    always_ff @(posedge clk) begin
        if (phase == ph_load) begin
            w_q <= w;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            acc_a_q <= '0;
            acc_b_q <= '0;
            sum     <= '0;
        end else begin
            if (acc_clr) begin
                acc_a_q <= '0;
                acc_b_q <= '0;
            end else if (phase == ph_wgt) begin
                acc_a_q <= acc_a_q + col_sum_a;
                acc_b_q <= acc_b_q + col_sum_b;
            end
            // Held until the next fin
            if (phase == ph_fin) begin
                sum <= {4'd0, diff_abs[acc_w:5]};
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/disto4x4_top.sv
/*
 * Weighted 4x4 spectral distortion, top level
 *   controller, two transform engines, one sum unit
 */

`timescale 1ns/1ps
`default_nettype none

module disto4x4_top import disto_pkg::*; #(
    parameter int PIX_W = 8
) (
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic                         start,
    input  logic [blk_area*PIX_W-1:0]    ina,
    input  logic [blk_area*PIX_W-1:0]    inb,
    input  logic [blk_area*weight_w-1:0] w,
    output logic [PIX_W+23:0]            sum,
    output logic                         done
);

    // --------------------
    // Control nets
    // --------------------

    phase_e     phase;
    logic [1:0] idx;
    logic       acc_clr;

    // Column idx of each transformed block
    logic [blk_n-1:0][PIX_W+4:0] coef_col_a;
    logic [blk_n-1:0][PIX_W+4:0] coef_col_b;

    // Sequencer
    disto_ctrl ctrl_i (
        .clk     (clk),
        .arst_n  (arst_n),
        .start   (start),
        .phase   (phase),
        .idx     (idx),
        .acc_clr (acc_clr),
        .done    (done)
    );

    // --------------------
    // Transforms
    // --------------------

    // Block a
    hadamard_4x4 #(
        .PIX_W (PIX_W)
    ) hadamard_a (
        .clk      (clk),
        .arst_n   (arst_n),
        .phase    (phase),
        .idx      (idx),
        .pix      (ina),
        .coef_col (coef_col_a)
    );

    // Block b
    hadamard_4x4 #(
        .PIX_W (PIX_W)
    ) hadamard_b (
        .clk      (clk),
        .arst_n   (arst_n),
        .phase    (phase),
        .idx      (idx),
        .pix      (inb),
        .coef_col (coef_col_b)
    );

    // Weighting and difference
    weighted_sum_diff #(
        .PIX_W (PIX_W)
    ) wsum_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .phase      (phase),
        .idx        (idx),
        .acc_clr    (acc_clr),
        .w          (w),
        .coef_col_a (coef_col_a),
        .coef_col_b (coef_col_b),
        .sum        (sum)
    );

endmodule

`default_nettype wire

//--- dv/disto4x4_props.sv
/*
 * Concurrent checks bound to the distortion top level
 *   idle left only on a start
 *   done latency, pulse width and origin
 *   done held low in reset
 */

`timescale 1ns/1ps
`default_nettype none

module disto4x4_props import disto_pkg::*; (
    input logic   clk,
    input logic   arst_n,
    input logic   start,
    input phase_e phase,
    input logic   done
);

    // Failed assertions, read back by the testbench
    int fail_cnt = 0;

    // --------------------
    // Start acceptance
    // --------------------

    // Phase only leaves idle on a start
    idle_exit_needs_start: assert property (
        @(posedge clk) disable iff (!arst_n)
        ($past(phase) == ph_idle && phase != ph_idle) |-> start
    ) else begin
        fail_cnt++;
        $error("phase left idle without start");
    end

    // --------------------
    // Done timing
    // --------------------

    // Registered 13 edges after the start edge, seen on the 14th
    done_latency: assert property (
        @(posedge clk) disable iff (!arst_n)
        (phase == ph_load) |=> (!done) [*13] ##1 done
    ) else begin
        fail_cnt++;
        $error("done not registered 13 edges after an accepted start");
    end

    // Single cycle pulse
    done_pulse: assert property (
        @(posedge clk) disable iff (!arst_n) done |=> !done
    ) else begin
        fail_cnt++;
        $error("done high for more than one cycle");
    end

    // Every done belongs to an accepted start
    done_origin: assert property (
        @(posedge clk) disable iff (!arst_n) $rose(done) |-> $past(phase == ph_load, 14)
    ) else begin
        fail_cnt++;
        $error("done without a matching start");
    end

    // No done while reset is applied
    done_in_reset: assert property (
        @(posedge clk) !arst_n |-> !done
    ) else begin
        fail_cnt++;
        $error("done high during reset");
    end

endmodule

bind disto4x4_top disto4x4_props props_i (
    .clk    (clk),
    .arst_n (arst_n),
    .start  (start),
    .phase  (phase),
    .done   (done)
);

`default_nettype wire

//--- dv/disto4x4_tb.sv
/*
 * Testbench for the weighted 4x4 distortion top level
 *   clock, reset, watchdog and input drive
 *   reference model of transform, weighting and difference
 *   directed and random tests, one report line per test
 */

`timescale 1ns/1ps
`default_nettype none

module disto4x4_tb
    import disto_pkg::*;
();

    localparam int pix_w      = 8;
    localparam int pix_bits   = blk_area * pix_w;
    localparam int wgt_bits   = blk_area * weight_w;
    localparam int sum_w      = pix_w + 24;
    localparam int clk_period = 10;
    // Operations started over the whole run
    localparam int num_ops    = 56;
    localparam int timeout_cycles = num_ops * 20 + 100;

    logic                clk;
    logic                arst_n;
    logic                start;
    logic [pix_bits-1:0] ina;
    logic [pix_bits-1:0] inb;
    logic [wgt_bits-1:0] w;
    logic [sum_w-1:0]    sum;
    logic                done;

    int    checks;
    int    errors;
    int    done_cnt;
    string test_name;
    int    test_err0;

    disto4x4_top #(
        .PIX_W (pix_w)
    ) dut_i (
        .clk    (clk),
        .arst_n (arst_n),
        .start  (start),
        .ina    (ina),
        .inb    (inb),
        .w      (w),
        .sum    (sum),
        .done   (done)
    );

    // --------------------
    // Clock, pulse count, watchdog
    // --------------------

    initial begin
        clk = 1'b0;
    end

    always #(clk_period / 2) clk = ~clk;

    // Done pulses seen at rising edges
    always @(posedge clk) begin
        if (done) begin
            done_cnt++;
        end
    end

    initial begin
        #(timeout_cycles * clk_period);
        $display("Timeout: run did not finish within %0d cycles", timeout_cycles);
        $display("=== FAIL ===");
        $finish;
    end

    // --------------------
    // Stimulus helpers
    // --------------------

    function automatic logic [pix_bits-1:0] random_block();
        logic [pix_bits-1:0] v;
        for (int i = 0; i < blk_area; i++) begin
            v[i*pix_w +: pix_w] = pix_w'($urandom_range(0, (1 << pix_w) - 1));
        end
        return v;
    endfunction

    function automatic logic [wgt_bits-1:0] random_weights();
        logic [wgt_bits-1:0] v;
        for (int i = 0; i < blk_area; i++) begin
            v[i*weight_w +: weight_w] = weight_w'($urandom_range(0, 65535));
        end
        return v;
    endfunction

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    // --------------------
    // Reference model
    // --------------------

    // 4-point butterfly, standard output order
    task automatic butterfly_ref(inout longint x0, inout longint x1,
                                 inout longint x2, inout longint x3);
        longint s0;
        longint s1;
        longint s2;
        longint s3;
        s0 = x0 + x2;
        s1 = x1 + x3;
        s2 = x1 - x3;
        s3 = x0 - x2;
        x0 = s0 + s1;
        x1 = s3 + s2;
        x2 = s3 - s2;
        x3 = s0 - s1;
    endtask

    // Sum of weight times |coefficient| for one block
    task automatic weighted_ref(input logic [pix_bits-1:0] blk,
                                input logic [wgt_bits-1:0] wv, output longint s);
        longint c[blk_area];
        longint m;
        for (int i = 0; i < blk_area; i++) begin
            c[i] = longint'(blk[i*pix_w +: pix_w]);
        end
        // Rows first
        for (int r = 0; r < blk_n; r++) begin
            butterfly_ref(c[r*blk_n], c[r*blk_n+1], c[r*blk_n+2], c[r*blk_n+3]);
        end
        // Then columns, stride of one row
        for (int k = 0; k < blk_n; k++) begin
            butterfly_ref(c[k], c[blk_n+k], c[2*blk_n+k], c[3*blk_n+k]);
        end
        s = 0;
        for (int i = 0; i < blk_area; i++) begin
            m = (c[i] < 0) ? -c[i] : c[i];
            s += m * longint'(wv[i*weight_w +: weight_w]);
        end
    endtask

    // |b - a| >> 5
    task automatic expected_sum(input logic [pix_bits-1:0] a, input logic [pix_bits-1:0] b,
                                input logic [wgt_bits-1:0] wv, output longint e);
        longint sa;
        longint sb;
        longint d;
        weighted_ref(a, wv, sa);
        weighted_ref(b, wv, sb);
        d = sb - sa;
        e = ((d < 0) ? -d : d) >> 5;
    endtask

    // --------------------
    // Checks and report
    // --------------------

    task automatic compare_value(input string name, input longint expected,
                                 input longint actual);
        checks++;
        assert (expected == actual) else begin
            $display("CHECK FAILED at %0t: %s expected %0d actual %0d",
                     $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic expect_true(input logic cond, input string what);
        checks++;
        assert (cond) else begin
            $display("ERROR at %0t: %s", $time, what);
            errors++;
        end
    endtask

    task automatic open_test(input string name);
        test_name = name;
        test_err0 = errors;
    endtask

    task automatic close_test();
        if (errors == test_err0) begin
            $display("test %s: ok", test_name);
        end else begin
            $display("test %s: %0d failed checks", test_name, errors - test_err0);
        end
    endtask

    // One operation, optionally with starts pulsed while busy
    task automatic run_op(input logic [pix_bits-1:0] a, input logic [pix_bits-1:0] b,
                          input logic [wgt_bits-1:0] wv, input bit busy,
                          output longint result, output int latency);
        longint expected;
        int     cyc;
        expected_sum(a, b, wv, expected);
        @(posedge clk);
        ina   <= a;
        inb   <= b;
        w     <= wv;
        start <= 1'b1;
        // Start edge
        @(posedge clk);
        cyc = 0;
        while (!done && cyc < 40) begin
            // Inputs only matter at the start edge
            if (cyc == 0 || (busy && (cyc == 3 || cyc == 8))) begin
                ina <= random_block();
                inb <= random_block();
                w   <= random_weights();
            end
            start <= busy && (cyc == 3 || cyc == 8);
            @(posedge clk);
            cyc++;
        end
        // Done is registered one edge before it is seen here
        latency = cyc - 1;
        result  = longint'(sum);
        expect_true(done, "no done pulse after a start in idle");
        compare_value("sum", expected, result);
        // Let the pulse drain before the caller looks at counts
        @(posedge clk);
    endtask

    // --------------------
    // Test sequence
    // --------------------

    initial begin
        longint              r1;
        longint              r2;
        longint              e1;
        int                  lat;
        int                  cnt0;
        logic [pix_bits-1:0] a;
        logic [pix_bits-1:0] b;
        logic [wgt_bits-1:0] wv;
        void'($urandom(32'h8e8b));
        arst_n   = 1'b0;
        start    = 1'b0;
        ina      = '0;
        inb      = '0;
        w        = '0;
        checks   = 0;
        errors   = 0;
        done_cnt = 0;
        // Reset for 3 cycles
        @(posedge clk);
        arst_n <= 1'b0;
        wait_cycles(3);
        arst_n <= 1'b1;
        @(posedge clk);

        open_test("reset_and_latency");
        compare_value("sum", 0, longint'(sum));
        compare_value("done", 0, longint'(done));
        cnt0 = done_cnt;
        run_op(random_block(), random_block(), random_weights(), 1'b0, r1, lat);
        compare_value("done latency", 13, longint'(lat));
        wait_cycles(4);
        compare_value("done pulses", 1, longint'(done_cnt - cnt0));
        close_test();

        open_test("equal_blocks");
        repeat (4) begin
            a = random_block();
            run_op(a, a, random_weights(), 1'b0, r1, lat);
            compare_value("sum", 0, r1);
        end
        close_test();

        open_test("random_blocks");
        repeat (40) begin
            run_op(random_block(), random_block(), random_weights(), 1'b0, r1, lat);
        end
        close_test();

        open_test("symmetry_extremes");
        repeat (3) begin
            a  = random_block();
            b  = random_block();
            wv = random_weights();
            expected_sum(a, b, wv, e1);
            run_op(a, b, wv, 1'b0, r1, lat);
            run_op(b, a, wv, 1'b0, r2, lat);
            // Swapped pair held to the unswapped model result
            compare_value("sum", e1, r2);
        end
        // Full scale against zero, largest weights
        expected_sum({pix_bits{1'b1}}, '0, {wgt_bits{1'b1}}, e1);
        run_op({pix_bits{1'b1}}, '0, {wgt_bits{1'b1}}, 1'b0, r1, lat);
        run_op('0, {pix_bits{1'b1}}, {wgt_bits{1'b1}}, 1'b0, r2, lat);
        compare_value("sum", e1, r2);
        close_test();

        open_test("busy_start");
        cnt0 = done_cnt;
        run_op(random_block(), random_block(), random_weights(), 1'b1, r1, lat);
        // Long enough for a late start to show its own done
        wait_cycles(20);
        compare_value("done pulses", 1, longint'(done_cnt - cnt0));
        compare_value("done latency", 13, longint'(lat));
        close_test();

        open_test("reset_mid_op");
        cnt0 = done_cnt;
        @(posedge clk);
        ina   <= random_block();
        inb   <= random_block();
        w     <= random_weights();
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        // Abort during the row pass
        wait_cycles(2);
        arst_n <= 1'b0;
        wait_cycles(3);
        arst_n <= 1'b1;
        wait_cycles(20);
        compare_value("done pulses", 0, longint'(done_cnt - cnt0));
        compare_value("sum", 0, longint'(sum));
        run_op(random_block(), random_block(), random_weights(), 1'b0, r1, lat);
        close_test();

        $display("Total: %0d checks, %0d failed, %0d assertion failures",
                 checks, errors, dut_i.props_i.fail_cnt);
        if (errors == 0 && dut_i.props_i.fail_cnt == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
hw/disto_pkg.sv
hw/disto_ctrl.sv
hw/hadamard_4x4.sv
hw/weighted_sum_diff.sv
hw/disto4x4_top.sv
dv/disto4x4_props.sv
dv/disto4x4_tb.sv
